/* rx_lbuf.f */
lbuf_pkg.sv
lbuf_if.sv
lbuf_host_ctrl.sv
lbuf_giver.sv
lbuf_writer.sv
rx_lbuf_top.sv
rx_lbuf_asserts.sv
tb_rx_lbuf.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_rx_lbuf
FILELIST  = rx_lbuf.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_rx_lbuf.sv */
////////////////////
// testbench for the rx lbuf DMA, random host, stream and write sink
// checked against a ping-pong reference model
////////////////////

`timescale 1ns/1ps

module tb_rx_lbuf import lbuf_pkg::*; ();

    localparam int          NUM_BUF = 40;                       // real posts
    localparam int          MAX_LEN = 16;
    localparam int          MAX_CYC = NUM_BUF * MAX_LEN * 8;    // cycle limit
    localparam logic [31:0] SEED    = 32'h09c6f4fc;

    logic              clk = 1'b0;
    logic              rst;
    logic              post_req, post_sel, post_ack;
    logic [ADDR_W-1:0] post_addr;
    logic [LEN_W-1:0]  post_len;
    logic              cpl_req, cpl_sel, cpl_ack;
    logic [DATA_W-1:0] rx_data;
    logic              rx_valid, rx_ready;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
    logic              wr_64b, wr_valid, wr_ready;

    ////////////////////
    // reference model state
    logic [31:0]       lcg = SEED;
    lbuf_addr_u        base [2];        // per slot post
    logic [LEN_W-1:0]  blen [2];
    logic [1:0]        posted = 2'b00;  // real post, freed once its cpl is presented
    logic [1:0]        full = 2'b00;    // all writes seen, cpl not acked yet
    logic              cur = 1'b0;      // ping-pong pointer, lbuf 1 first
    int                idx = 0;         // write index in current buffer
    logic              rx_took = 1'b0;  // word transfers at the coming edge
    logic [DATA_W-1:0] rx_q [$];        // accepted words, stream order
    logic              cpl_q [$];       // predicted completion slots
    int                n_post = 0;
    int                n_cpl = 0;
    int                n_cyc = 0;

    rx_lbuf_top i_dut (.*);

    bind lbuf_giver rx_lbuf_asserts i_asserts (
        .clk, .rst, .en(lbuf.en), .dn(lbuf.dn), .gv_st, .wt1(lbuf1_wt), .wt2(lbuf2_wt)
    );

    always #2 clk = ~clk;   // 4 ns period

    function automatic logic [31:0] next_rand();
        lcg = lcg * 32'd1664525 + 32'd1013904223;
        return lcg;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;                 // drive point
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_wr(input lbuf_addr_u got_a, input lbuf_addr_u exp_a,
                            input logic [DATA_W-1:0] got_d, input logic [DATA_W-1:0] exp_d,
                            input logic got_f, input logic exp_f);
        if (got_a != exp_a || got_d != exp_d || got_f != exp_f)
            abort_run($sformatf("Fail at %0t ns: write %h %h %b, expected %h %h %b",
                                $time, got_a.full, got_d, got_f, exp_a.full, exp_d, exp_f));
    endtask

    task automatic check_cpl(input logic got_s, input logic exp_s);
        if (got_s != exp_s)
            abort_run($sformatf("Fail at %0t ns: completion for lbuf %0d, expected lbuf %0d",
                                $time, got_s + 1, exp_s + 1));
    endtask

    // four-phase post, starts and ends at the drive point
    task automatic post(input logic sel, input lbuf_addr_u addr, input logic [LEN_W-1:0] len);
        post_sel  = sel;
        post_addr = addr.full;
        post_len  = len;
        post_req  = 1'b1;
        next_cycle();
        while (!post_ack) next_cycle();
        post_req = 1'b0;
        next_cycle();
        while (post_ack) next_cycle();
    endtask

    ////////////////////
    // monitor, mid-cycle where everything is settled
    always @(negedge clk) begin
        lbuf_addr_u exp_a;
        lbuf_addr_u got_a;
        if (!rst) begin
            n_cyc = n_cyc + 1;
            if (n_cyc >= MAX_CYC)
                abort_run($sformatf("timeout after %0d cycles, %0d of %0d buffers completed",
                                    n_cyc, n_cpl, NUM_BUF));
            if (i_dut.i_giver.i_asserts.n_fail != 0)
                abort_run("a giver assertion failed");
            if (wr_valid && wr_ready) begin
                if (!posted[cur] || full[cur] || rx_q.size() == 0)
                    abort_run($sformatf("write at %0t ns with no buffer or word pending", $time));
                exp_a.full = base[cur].full + ADDR_W'(idx * WORD_BYTES);  // step by 8
                got_a.full = wr_addr;
                check_wr(got_a, exp_a, wr_data, rx_q.pop_front(), wr_64b, |base[cur].half.hi);
                idx = idx + 1;
                if (idx == int'(blen[cur])) begin   // buffer full, other slot next
                    full[cur] = 1'b1;
                    cpl_q.push_back(cur);
                    cur = ~cur;
                    idx = 0;
                end
            end
            rx_took = rx_valid && rx_ready;
            if (rx_took) rx_q.push_back(rx_data);
        end
    end

    ////////////////////
    // stream source and write sink
    initial begin
        logic [31:0] r;
        wait (rst === 1'b0);
        forever begin
            next_cycle();
            r = next_rand();
            wr_ready = (r[1:0] != 2'b00);       // random back-pressure
            if (rx_took || !rx_valid) begin     // hold a word until taken
                rx_valid = (r[3:2] != 2'b00);
                rx_data  = {next_rand(), next_rand()};
            end
        end
    end

    // completion side of the host, acks after a random delay
    initial begin
        int   d;
        logic s;
        wait (rst === 1'b0);
        forever begin
            @(negedge clk);
            if (cpl_req) begin
                s = cpl_sel;
                if (cpl_q.size() == 0)
                    abort_run($sformatf("completion for lbuf %0d before its buffer was full",
                                        s + 1));
                check_cpl(s, cpl_q.pop_front());
                posted[s] = 1'b0;   // open to a new post, still held until the ack
                d = next_rand() % 6;
                repeat (1 + d) next_cycle();
                cpl_ack = 1'b1;
                while (cpl_req) next_cycle();
                cpl_ack = 1'b0;
                @(negedge clk);
                full[s] = 1'b0;     // wait over, slot may be written again
                n_cpl = n_cpl + 1;
            end
        end
    end

    ////////////////////
    // reset, buffer posts and the end of the run
    initial begin
        logic [31:0]      r;
        logic             s;
        lbuf_addr_u       a;
        logic [LEN_W-1:0] len;
        rst       = 1'b1;
        post_req  = 1'b0;
        post_sel  = 1'b0;
        post_addr = '0;
        post_len  = '0;
        cpl_ack   = 1'b0;
        rx_data   = '0;
        rx_valid  = 1'b0;
        wr_ready  = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        while (n_post < NUM_BUF) begin
            r = next_rand();
            repeat (1 + r[9:8]) next_cycle();
            s          = r[0];
            a.half.hi  = r[1] ? next_rand() : 32'd0;    // 4DW or 3DW address
            a.half.lo  = next_rand() & 32'hffff_fff8;
            len        = {28'd0, r[7:4]} + 32'd1;       // 1 to 16 words
            if (!posted[s]) begin
                // may land while the slot still waits on its completion
                base[s]   = a;
                blen[s]   = len;
                posted[s] = 1'b1;
                n_post    = n_post + 1;
                post(s, a, len);
            end else if (!full[s] && r[2]) begin
                post(s, a, len);    // duplicate, slot still enabled
            end
        end
        while (n_cpl < NUM_BUF) @(posedge clk);
        if (rx_q.size() == 0 && cpl_q.size() == 0 && i_dut.i_giver.i_asserts.n_fail == 0) begin
            $display("TEST PASS");
        end else begin
            $display("words or completions left over, or an assertion failed");
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* rx_lbuf_asserts.sv */
////////////////////
// giver checks, bound into lbuf_giver from the testbench
////////////////////

`timescale 1ns/1ps

module rx_lbuf_asserts import lbuf_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       en,       // lbuf.en
    input logic       dn,       // lbuf.dn
    input logic [1:0] gv_st,
    input logic       wt1,
    input logic       wt2
);

    int         n_fail = 0;     // failed assertions so far
    logic       en_q;
    logic [1:0] last_st;        // busy state of the last giving

    always_ff @(posedge clk) begin
        if (rst) begin
            en_q    <= 1'b0;
            last_st <= GV_BUSY2;    // so the first giving must be lbuf 1
        end else begin
            en_q <= en;
            if (en && !en_q) last_st <= gv_st;
        end
    end

    ////////////////////
    // en held until dn, dropped right after
    a_en_hold: assert property (@(posedge clk) disable iff (rst) en && !dn |=> en)
        else begin n_fail++; $error("en dropped before dn"); end
    a_en_drop: assert property (@(posedge clk) disable iff (rst) dn |=> !en)
        else begin n_fail++; $error("en still high after dn"); end

    // strict ping-pong, never the same slot twice in a row
    a_order: assert property (@(posedge clk) disable iff (rst) en && !en_q |-> gv_st != last_st)
        else begin n_fail++; $error("same slot given twice in a row"); end

    // a slot waiting on its completion is not handed over
    a_wait1: assert property (@(posedge clk) disable iff (rst) gv_st == GV_OFFER1 && wt1 |=> !en)
        else begin n_fail++; $error("lbuf 1 given while waiting"); end
    a_wait2: assert property (@(posedge clk) disable iff (rst) gv_st == GV_OFFER2 && wt2 |=> !en)
        else begin n_fail++; $error("lbuf 2 given while waiting"); end

endmodule

/* rx_lbuf_top.sv */
////////////////////
// rx lbuf DMA top, host post and completion, packet stream in,
// addressed memory writes out
////////////////////

`timescale 1ns/1ps

module rx_lbuf_top import lbuf_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    // host post
    input  logic              post_req,
    input  logic              post_sel,
    input  logic [ADDR_W-1:0] post_addr,
    input  logic [LEN_W-1:0]  post_len,
    output logic              post_ack,

    // host completion
    output logic              cpl_req,
    output logic              cpl_sel,
    input  logic              cpl_ack,

    // packet stream
    input  logic [DATA_W-1:0] rx_data,
    input  logic              rx_valid,
    output logic              rx_ready,

    // memory writes
    output logic [ADDR_W-1:0] wr_addr,
    output logic [DATA_W-1:0] wr_data,
    output logic              wr_64b,
    output logic              wr_valid,
    input  logic              wr_ready
);

    // slot fields, host ctrl <-> giver
    lbuf_addr_u       lbuf1_addr;
    logic [LEN_W-1:0] lbuf1_len;
    logic             lbuf1_en;
    logic             lbuf1_wt;
    logic             lbuf1_dn;
    lbuf_addr_u       lbuf2_addr;
    logic [LEN_W-1:0] lbuf2_len;
    logic             lbuf2_en;
    logic             lbuf2_wt;
    logic             lbuf2_dn;

    lbuf_if lbuf ();    // giver -> writer

    ////////////////////
    // input side
    lbuf_host_ctrl i_host_ctrl (
        .clk, .rst,
        .post_req, .post_sel, .post_addr, .post_len, .post_ack,
        .cpl_req, .cpl_sel, .cpl_ack,
        .lbuf1_addr, .lbuf1_len, .lbuf1_en, .lbuf1_wt, .lbuf1_dn,
        .lbuf2_addr, .lbuf2_len, .lbuf2_en, .lbuf2_wt, .lbuf2_dn
    );

    // ping-pong
    lbuf_giver i_giver (
        .clk, .rst,
        .lbuf1_addr, .lbuf1_len, .lbuf1_en, .lbuf1_wt, .lbuf1_dn,
        .lbuf2_addr, .lbuf2_len, .lbuf2_en, .lbuf2_wt, .lbuf2_dn,
        .lbuf (lbuf.giver)
    );

    // output side
    lbuf_writer i_writer (
        .clk, .rst,
        .rx_data, .rx_valid, .rx_ready,
        .wr_addr, .wr_data, .wr_64b, .wr_valid, .wr_ready,
        .lbuf (lbuf.taker)
    );

endmodule

/* lbuf_writer.sv */
////////////////////
// lbuf writer, one memory write per accepted packet word until the
// current buffer is full, then reports it done to the giver
////////////////////

`timescale 1ns/1ps

module lbuf_writer import lbuf_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    // packet words in
    input  logic [DATA_W-1:0] rx_data,
    input  logic              rx_valid,
    output logic              rx_ready,

    // memory writes out
    output logic [ADDR_W-1:0] wr_addr,
    output logic [DATA_W-1:0] wr_data,
    output logic              wr_64b,
    output logic              wr_valid,
    input  logic              wr_ready,

    // current buffer from giver
    lbuf_if.taker             lbuf
);

    logic [1:0]        wr_st;
    logic [ADDR_W-1:0] run_addr;    // next write address
    logic [LEN_W-1:0]  cnt;         // words still to accept
    logic              wr_last;     // output reg holds the last word
    logic              rx_fire;
    logic              wr_fire;

    // output reg free this cycle, or emptying
    assign rx_ready = (wr_st == WR_RUN) && (cnt != '0) && (!wr_valid || wr_ready);
    assign rx_fire  = rx_valid && rx_ready;
    assign wr_fire  = wr_valid && wr_ready;
    assign lbuf.dn  = wr_fire && wr_last;   // same cycle as last transfer

    ////////////////////
    // buffer FSM and counters
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_st <= WR_IDLE;
            cnt   <= '0;
        end else begin
            case (wr_st)
                WR_IDLE: begin
                    if (lbuf.en) begin      // en seen low before, so a rise
                        run_addr <= lbuf.addr.full;
                        cnt      <= lbuf.len;
                        wr_st    <= WR_RUN;
                    end
                end
                WR_RUN: begin
                    if (rx_fire) begin
                        run_addr <= run_addr + ADDR_W'(WORD_BYTES);
                        cnt      <= cnt - 1'b1;
                    end
                    if (lbuf.dn) wr_st <= WR_WAIT;
                end
                default: begin              // WR_WAIT, giver drops en next
                    if (!lbuf.en) wr_st <= WR_IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // output register
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_valid <= 1'b0;
        end else if (rx_fire) begin
            wr_valid <= 1'b1;
        end else if (wr_ready) begin
            wr_valid <= 1'b0;               // drained, nothing new
        end
    end

    // payload, loads only on an accepted word
    always_ff @(posedge clk) begin
        if (rx_fire) begin
            wr_addr <= run_addr;
            wr_data <= rx_data;
            wr_64b  <= lbuf.is64;
            wr_last <= (cnt == LEN_W'(1));
        end
    end

endmodule

/* lbuf_giver.sv */
////////////////////
// ping-pong giver, hands lbuf 1 then lbuf 2 to the writer, forever
// in that order, skipping nothing
////////////////////

`timescale 1ns/1ps

module lbuf_giver import lbuf_pkg::*; (
    input  logic             clk,
    input  logic             rst,

    // slot 1 from host control
    input  lbuf_addr_u       lbuf1_addr,
    input  logic [LEN_W-1:0] lbuf1_len,
    input  logic             lbuf1_en,
    input  logic             lbuf1_wt,
    output logic             lbuf1_dn,

    // slot 2 from host control
    input  lbuf_addr_u       lbuf2_addr,
    input  logic [LEN_W-1:0] lbuf2_len,
    input  logic             lbuf2_en,
    input  logic             lbuf2_wt,
    output logic             lbuf2_dn,

    // current buffer to writer
    lbuf_if.giver            lbuf
);

    logic [1:0] gv_st;

    ////////////////////
    // giver FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            gv_st    <= GV_OFFER1;      // lbuf 1 goes first
            lbuf.en  <= 1'b0;
            lbuf1_dn <= 1'b0;
            lbuf2_dn <= 1'b0;
        end else begin
            lbuf1_dn <= 1'b0;           // pulses
            lbuf2_dn <= 1'b0;
            case (gv_st)
                GV_OFFER1: begin
                    // track slot fields until it is taken
                    lbuf.addr <= lbuf1_addr;
                    lbuf.len  <= lbuf1_len;
                    lbuf.is64 <= |lbuf1_addr.half.hi;
                    if (lbuf1_en && !lbuf1_wt) begin
                        lbuf.en <= 1'b1;
                        gv_st   <= GV_BUSY1;
                    end
                end
                GV_BUSY1: begin
                    if (lbuf.dn) begin
                        lbuf.en  <= 1'b0;
                        lbuf1_dn <= 1'b1;   // to host ctrl
                        gv_st    <= GV_OFFER2;
                    end
                end
                GV_OFFER2: begin
                    lbuf.addr <= lbuf2_addr;
                    lbuf.len  <= lbuf2_len;
                    lbuf.is64 <= |lbuf2_addr.half.hi;
                    if (lbuf2_en && !lbuf2_wt) begin
                        lbuf.en <= 1'b1;
                        gv_st   <= GV_BUSY2;
                    end
                end
                default: begin              // GV_BUSY2
                    if (lbuf.dn) begin
                        lbuf.en  <= 1'b0;
                        lbuf2_dn <= 1'b1;
                        gv_st    <= GV_OFFER1;  // back to lbuf 1
                    end
                end
            endcase
        end
    end

endmodule

/* lbuf_host_ctrl.sv */
////////////////////
// host side of the lbuf engine, takes buffer posts and reports
// completions, both over four-phase req/ack
////////////////////

`timescale 1ns/1ps

module lbuf_host_ctrl import lbuf_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    // host post
    input  logic              post_req,
    input  logic              post_sel,
    input  logic [ADDR_W-1:0] post_addr,
    input  logic [LEN_W-1:0]  post_len,
    output logic              post_ack,

    // host completion
    output logic              cpl_req,
    output logic              cpl_sel,
    input  logic              cpl_ack,

    // slot 1 to giver
    output lbuf_addr_u        lbuf1_addr,
    output logic [LEN_W-1:0]  lbuf1_len,
    output logic              lbuf1_en,
    output logic              lbuf1_wt,
    input  logic              lbuf1_dn,

    // slot 2 to giver
    output lbuf_addr_u        lbuf2_addr,
    output logic [LEN_W-1:0]  lbuf2_len,
    output logic              lbuf2_en,
    output logic              lbuf2_wt,
    input  logic              lbuf2_dn
);

    logic       pst_st;     // post FSM
    logic [1:0] cpl_st;     // completion FSM
    logic       pend1;      // slot 1 done, not yet presented
    logic       pend2;
    logic       cpl_busy;

    assign cpl_busy = (cpl_st != CPL_IDLE);

    // wait covers pending and the handshake itself
    assign lbuf1_wt = pend1 | (cpl_busy && cpl_sel == SEL_LBUF1);
    assign lbuf2_wt = pend2 | (cpl_busy && cpl_sel == SEL_LBUF2);

    ////////////////////
    // post handshake and slot storage
    always_ff @(posedge clk) begin
        if (rst) begin
            pst_st   <= PST_IDLE;
            post_ack <= 1'b0;
            lbuf1_en <= 1'b0;
            lbuf2_en <= 1'b0;
        end else begin
            if (lbuf1_dn) lbuf1_en <= 1'b0;     // buffer full, slot free
            if (lbuf2_dn) lbuf2_en <= 1'b0;
            case (pst_st)
                PST_IDLE: begin
                    if (post_req) begin
                        post_ack <= 1'b1;
                        pst_st   <= PST_ACK;
                        // a post to a slot still enabled is acked and dropped
                        if (post_sel == SEL_LBUF1 && !lbuf1_en) begin
                            lbuf1_addr.full <= post_addr;
                            lbuf1_len       <= post_len;
                            lbuf1_en        <= 1'b1;
                        end
                        if (post_sel == SEL_LBUF2 && !lbuf2_en) begin
                            lbuf2_addr.full <= post_addr;
                            lbuf2_len       <= post_len;
                            lbuf2_en        <= 1'b1;
                        end
                    end
                end
                default: begin              // PST_ACK
                    if (!post_req) begin
                        post_ack <= 1'b0;
                        pst_st   <= PST_IDLE;
                    end
                end
            endcase
        end
    end

    ////////////////////
    // completion handshake, slot 1 wins a tie
    always_ff @(posedge clk) begin
        if (rst) begin
            cpl_st  <= CPL_IDLE;
            cpl_req <= 1'b0;
            pend1   <= 1'b0;
            pend2   <= 1'b0;
        end else begin
            case (cpl_st)
                CPL_IDLE: begin
                    if (pend1) begin
                        pend1   <= 1'b0;
                        cpl_sel <= SEL_LBUF1;
                        cpl_req <= 1'b1;
                        cpl_st  <= CPL_REQ;
                    end else if (pend2) begin
                        pend2   <= 1'b0;
                        cpl_sel <= SEL_LBUF2;
                        cpl_req <= 1'b1;
                        cpl_st  <= CPL_REQ;
                    end
                end
                CPL_REQ: begin
                    if (cpl_ack) begin
                        cpl_req <= 1'b0;
                        cpl_st  <= CPL_END;
                    end
                end
                default: begin              // CPL_END, wait for ack low
                    if (!cpl_ack) cpl_st <= CPL_IDLE;
                end
            endcase
            if (lbuf1_dn) pend1 <= 1'b1;    // set wins over the clear above
            if (lbuf2_dn) pend2 <= 1'b1;
        end
    end

endmodule

/* lbuf_if.sv */
////////////////////
// current lbuf from giver to writer
////////////////////

`timescale 1ns/1ps

interface lbuf_if import lbuf_pkg::*; ();

    lbuf_addr_u        addr;    // base address
    logic [LEN_W-1:0]  len;     // words to write
    logic              en;      // buffer handed over
    logic              is64;    // hi half of addr nonzero
    logic              dn;      // last write transferred, one cycle

    // giver side, holds fields stable while en is high
    modport giver (
        output addr,
        output len,
        output en,
        output is64,
        input  dn
    );

    // writer side
    modport taker (
        input  addr,
        input  len,
        input  en,
        input  is64,
        output dn
    );

endinterface

/* lbuf_pkg.sv */
////////////////////
// shared widths, FSM encodings and the lbuf address union
// import with lbuf_pkg::* in the module header
////////////////////

package lbuf_pkg;

    ////////////////////
    // widths
    localparam int ADDR_W     = 64;     // host address
    localparam int LEN_W      = 32;     // buffer length in words
    localparam int DATA_W     = 64;     // packet word
    localparam int WORD_BYTES = 8;      // address step per word

    // slot select on post and completion
    localparam logic SEL_LBUF1 = 1'b0;
    localparam logic SEL_LBUF2 = 1'b1;

    ////////////////////
    // FSM encodings
    localparam logic       PST_IDLE  = 1'b0;    // post handshake
    localparam logic       PST_ACK   = 1'b1;
    localparam logic [1:0] CPL_IDLE  = 2'd0;    // completion handshake
    localparam logic [1:0] CPL_REQ   = 2'd1;
    localparam logic [1:0] CPL_END   = 2'd2;
    localparam logic [1:0] GV_OFFER1 = 2'd0;    // ping-pong giver
    localparam logic [1:0] GV_BUSY1  = 2'd1;
    localparam logic [1:0] GV_OFFER2 = 2'd2;
    localparam logic [1:0] GV_BUSY2  = 2'd3;
    localparam logic [1:0] WR_IDLE   = 2'd0;    // writer
    localparam logic [1:0] WR_RUN    = 2'd1;
    localparam logic [1:0] WR_WAIT   = 2'd2;

    ////////////////////
    // host address, full word or split into halves
    typedef struct packed {
        logic [ADDR_W/2-1:0] hi;    // nonzero -> needs 4DW header
        logic [ADDR_W/2-1:0] lo;
    } lbuf_addr_s;

    typedef union packed {
        logic [ADDR_W-1:0] full;
        lbuf_addr_s        half;
    } lbuf_addr_u;

endpackage
